/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        NOP,
        INVALID,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        LUI,
        LW,
        SW,
        BEQ,
        BNE,
        JAL
    } op_e;

    // one instruction word, seen as R/I or as S/B format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } sb;
    } instr_u;

    // operations that write a destination register
    function automatic logic op_writes(op_e op);
        return !(op inside {NOP, INVALID, SW, BEQ, BNE});
    endfunction

endpackage

/* rv_fetch.sv */
module rv_fetch
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall_i,
    input  logic             hazard_i,
    input  logic             jump_i,
    input  logic [XLEN-1:0]  jump_target_i,
    output logic [XLEN-1:0]  instruction_address_o,
    output logic [XLEN-1:0]  pc_o,
    output logic [TAG_W-1:0] tag_o
);

    logic [XLEN-1:0]  pc;
    logic [TAG_W-1:0] fetch_tag;

    assign instruction_address_o = pc;

    // pc_o/tag_o follow the address whose word arrives next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= RESET_VECTOR;
            pc_o      <= RESET_VECTOR;
            fetch_tag <= '0;
            // word seen right after reset is junk, tag it as killed
            tag_o     <= '1;
        end else if (jump_i) begin
            pc        <= jump_target_i;
            fetch_tag <= fetch_tag + 1'b1;
            pc_o      <= pc;
            tag_o     <= fetch_tag;
        end else if (!stall_i && !hazard_i) begin
            pc        <= pc + XLEN'(4);
            pc_o      <= pc;
            tag_o     <= fetch_tag;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* rv_decode.sv */
module rv_decode
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  logic                  jump_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output op_e                   op_o,
    output logic [XLEN-1:0]       first_operand_o,
    output logic [XLEN-1:0]       second_operand_o,
    output logic [XLEN-1:0]       store_data_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [TAG_W-1:0]      tag_o
);

    instr_u          instr;
    logic [XLEN-1:0] saved_word;
    logic            replay;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    op_e             op;
    logic [XLEN-1:0] second, extra;
    logic            use_rs1, use_rs2;

    // memory re-reads the held fetch address, so replay the saved word after a hold
    assign instr = replay ? saved_word : instruction_i;
    assign rs1_o = instr.ri.rs1;
    assign rs2_o = instr.ri.rs2;

    assign imm_i = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
    assign imm_s = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
    assign imm_b = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_lo[0], instr.sb.imm_hi[5:0],
                    instr.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.ri.funct7, instr.ri.rs2, instr.ri.rs1, instr.ri.funct3, 12'b0};
    assign imm_j = {{12{instr.ri.funct7[6]}}, instr.ri.rs1, instr.ri.funct3, instr.ri.rs2[0],
                    instr.ri.funct7[5:0], instr.ri.rs2[4:1], 1'b0};

    always_comb begin
        op      = INVALID;
        second  = imm_i;
        extra   = rs2_data_i;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (instr.ri.opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (instr.ri.funct3)
                    3'b000: begin
                        if (instr.ri.opcode == OPC_OP && instr.ri.funct7 == 7'b0100000) begin
                            op = SUB;
                        end else begin
                            op = ADD;
                        end
                    end
                    3'b010:  op = SLT;
                    3'b011:  op = SLTU;
                    3'b100:  op = XOR;
                    3'b110:  op = OR;
                    3'b111:  op = AND;
                    default: op = INVALID;
                endcase
                if (instr.ri.opcode == OPC_OP) begin
                    second  = rs2_data_i;
                    use_rs2 = 1'b1;
                end
            end
            OPC_LUI: begin
                op      = LUI;
                second  = imm_u;
                use_rs1 = 1'b0;
            end
            OPC_LOAD: op = (instr.ri.funct3 == 3'b010) ? LW : INVALID;
            OPC_STORE: begin
                op      = (instr.sb.funct3 == 3'b010) ? SW : INVALID;
                second  = imm_s;
                use_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                if (instr.sb.funct3 == 3'b000) begin
                    op = BEQ;
                end else if (instr.sb.funct3 == 3'b001) begin
                    op = BNE;
                end
                second  = rs2_data_i;
                // branch offset rides in the store data slot
                extra   = imm_b;
                use_rs2 = 1'b1;
            end
            OPC_JAL: begin
                op      = JAL;
                second  = imm_j;
                use_rs1 = 1'b0;
            end
            default: op = INVALID;
        endcase
    end

    // writer still in execute, or a load right behind a store (shared memory port)
    assign hazard_o = (op_writes(op_o) && rd_o != '0 &&
                       ((use_rs1 && rs1_o == rd_o) || (use_rs2 && rs2_o == rd_o)))
                    || (op == LW && op_o == SW);

    always_ff @(posedge clk) begin
        if (reset) begin
            replay <= 1'b0;
            op_o   <= NOP;
        end else begin
            replay <= stall_i | hazard_o;
            if (!stall_i) begin
                op_o <= (hazard_o || jump_i) ? NOP : op;
            end
        end
    end

    always_ff @(posedge clk) begin
        saved_word <= instr;
        if (!stall_i) begin
            first_operand_o  <= use_rs1 ? rs1_data_i : '0;
            second_operand_o <= second;
            store_data_o     <= extra;
            pc_o             <= pc_i;
            rd_o             <= instr.ri.rd;
            tag_o            <= tag_i;
        end
    end

endmodule

/* rv_regbank.sv */
module rv_regbank
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  write_enable_i,
    input  logic [XLEN-1:0]       data_i,
    output logic [XLEN-1:0]       data1_o,
    output logic [XLEN-1:0]       data2_o
);

    // x0 is not stored
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (write_enable_i) begin
            regs[rd_i] <= data_i;
        end
    end

    // write-through of the retiring result
    always_comb begin
        if (rs1_i == '0) begin
            data1_o = '0;
        end else if (write_enable_i && rd_i == rs1_i) begin
            data1_o = data_i;
        end else begin
            data1_o = regs[rs1_i];
        end
        if (rs2_i == '0) begin
            data2_o = '0;
        end else if (write_enable_i && rd_i == rs2_i) begin
            data2_o = data_i;
        end else begin
            data2_o = regs[rs2_i];
        end
    end

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        write_enable_i |-> rd_i != '0);

endmodule

/* rv_execute.sv */
module rv_execute
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  op_e                   op_i,
    input  logic [XLEN-1:0]       first_operand_i,
    input  logic [XLEN-1:0]       second_operand_i,
    input  logic [XLEN-1:0]       store_data_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [TAG_W-1:0]      tag_i,
    output logic                  mem_read_o,
    output logic [XLEN-1:0]       mem_read_address_o,
    output op_e                   op_o,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       store_data_o,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [TAG_W-1:0]      tag_o
);

    logic [XLEN-1:0] sum, result, offset;
    logic            taken;

    assign sum = first_operand_i + second_operand_i;

    // load request goes out now, data lands when the LW reaches retire
    assign mem_read_o         = (op_i == LW) && !stall_i;
    assign mem_read_address_o = sum;

    always_comb begin
        case (op_i)
            ADD, LW, SW: result = sum;
            SUB:  result = first_operand_i - second_operand_i;
            AND:  result = first_operand_i & second_operand_i;
            OR:   result = first_operand_i | second_operand_i;
            XOR:  result = first_operand_i ^ second_operand_i;
            SLT:  result = {{(XLEN-1){1'b0}},
                            $signed(first_operand_i) < $signed(second_operand_i)};
            SLTU: result = {{(XLEN-1){1'b0}}, first_operand_i < second_operand_i};
            LUI:  result = second_operand_i;
            JAL:  result = pc_i + XLEN'(4);
            default: result = '0;
        endcase
    end

    // JAL offset is the second operand, branch offset comes in the store data slot
    assign offset = (op_i == JAL) ? second_operand_i : store_data_i;

    always_comb begin
        case (op_i)
            BEQ:     taken = (first_operand_i == second_operand_i);
            BNE:     taken = (first_operand_i != second_operand_i);
            JAL:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_o   <= NOP;
            jump_o <= 1'b0;
        end else if (!stall_i) begin
            op_o   <= op_i;
            jump_o <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o      <= result;
            store_data_o  <= store_data_i;
            jump_target_o <= pc_i + offset;
            rd_o          <= rd_i;
            tag_o         <= tag_i;
        end
    end

endmodule

/* rv_retire.sv */
module rv_retire
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  op_e                   op_i,
    input  logic [XLEN-1:0]       result_i,
    input  logic [XLEN-1:0]       store_data_i,
    input  logic                  jump_i,
    input  logic [XLEN-1:0]       jump_target_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  logic                  mem_read_i,
    input  logic [XLEN-1:0]       mem_read_address_i,
    input  logic [XLEN-1:0]       mem_data_i,
    output logic                  regbank_write_enable_o,
    output logic [REG_ADDR_W-1:0] regbank_rd_o,
    output logic [XLEN-1:0]       regbank_data_o,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o,
    output logic [TAG_W-1:0]      current_tag_o,
    output logic                  mem_operation_enable_o,
    output logic [3:0]            mem_write_enable_o,
    output logic [XLEN-1:0]       mem_address_o,
    output logic [XLEN-1:0]       mem_data_o
);

    logic            active, store, held;
    logic [XLEN-1:0] load_data, load_hold;

    // live only with the current tag, and nothing leaves during stall
    assign active = (tag_i == current_tag_o) && !stall_i;
    assign store  = active && op_i == SW;

    // load data is valid only in the first retire cycle, keep it across a stall
    assign load_data = held ? load_hold : mem_data_i;

    assign regbank_write_enable_o = active && op_writes(op_i) && rd_i != '0;
    assign regbank_rd_o           = rd_i;
    assign regbank_data_o         = (op_i == LW) ? load_data : result_i;

    assign jump_o        = active && jump_i;
    assign jump_target_o = jump_target_i;

    assign mem_write_enable_o     = store ? 4'b1111 : 4'b0000;
    assign mem_address_o          = {store ? result_i[XLEN-1:2] : mem_read_address_i[XLEN-1:2],
                                     2'b00};
    assign mem_data_o             = store_data_i;
    assign mem_operation_enable_o = store || mem_read_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag_o <= '0;
            held          <= 1'b0;
        end else begin
            held <= stall_i;
            if (jump_o) begin
                current_tag_o <= current_tag_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        load_hold <= load_data;
    end

    one_mem_access: assert property (@(posedge clk) disable iff (reset)
        !(store && mem_read_i));

endmodule

/* rv_core.sv */
module rv_core
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] mem_data_i,
    output logic [XLEN-1:0] instruction_address_o,
    output logic            mem_operation_enable_o,
    output logic [3:0]      mem_write_enable_o,
    output logic [XLEN-1:0] mem_address_o,
    output logic [XLEN-1:0] mem_data_o
);

    // fetch and retire control
    logic                  hazard, jump;
    logic [XLEN-1:0]       jump_target;
    logic [TAG_W-1:0]      current_tag;
    logic [XLEN-1:0]       pc_decode;
    logic [TAG_W-1:0]      tag_decode;

    // register bank
    logic [REG_ADDR_W-1:0] rs1, rs2, rd_wb;
    logic [XLEN-1:0]       rs1_data, rs2_data, data_wb;
    logic                  we_wb;

    // decode to execute
    op_e                   op_execute;
    logic [XLEN-1:0]       first_execute, second_execute, store_data_execute, pc_execute;
    logic [REG_ADDR_W-1:0] rd_execute;
    logic [TAG_W-1:0]      tag_execute;

    // execute to retire
    op_e                   op_retire;
    logic [XLEN-1:0]       result_retire, store_data_retire, jump_target_retire;
    logic [XLEN-1:0]       mem_read_address;
    logic [REG_ADDR_W-1:0] rd_retire;
    logic [TAG_W-1:0]      tag_retire;
    logic                  jump_retire, mem_read;

    rv_fetch #(.RESET_VECTOR(RESET_VECTOR)) fetch_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard),
        .jump_i(jump), .jump_target_i(jump_target),
        .instruction_address_o(instruction_address_o),
        .pc_o(pc_decode), .tag_o(tag_decode)
    );

    rv_decode decode_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .instruction_i(instruction_i),
        .pc_i(pc_decode), .tag_i(tag_decode), .jump_i(jump),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .rs1_o(rs1), .rs2_o(rs2),
        .hazard_o(hazard), .op_o(op_execute), .first_operand_o(first_execute),
        .second_operand_o(second_execute), .store_data_o(store_data_execute),
        .pc_o(pc_execute), .rd_o(rd_execute), .tag_o(tag_execute)
    );

    rv_regbank regbank_i (
        .clk(clk), .reset(reset), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd_wb),
        .write_enable_i(we_wb), .data_i(data_wb), .data1_o(rs1_data), .data2_o(rs2_data)
    );

    rv_execute execute_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .op_i(op_execute),
        .first_operand_i(first_execute), .second_operand_i(second_execute),
        .store_data_i(store_data_execute), .pc_i(pc_execute), .rd_i(rd_execute),
        .tag_i(tag_execute), .mem_read_o(mem_read), .mem_read_address_o(mem_read_address),
        .op_o(op_retire), .result_o(result_retire), .store_data_o(store_data_retire),
        .jump_o(jump_retire), .jump_target_o(jump_target_retire),
        .rd_o(rd_retire), .tag_o(tag_retire)
    );

    rv_retire retire_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .op_i(op_retire),
        .result_i(result_retire), .store_data_i(store_data_retire), .jump_i(jump_retire),
        .jump_target_i(jump_target_retire), .rd_i(rd_retire), .tag_i(tag_retire),
        .mem_read_i(mem_read), .mem_read_address_i(mem_read_address), .mem_data_i(mem_data_i),
        .regbank_write_enable_o(we_wb), .regbank_rd_o(rd_wb), .regbank_data_o(data_wb),
        .jump_o(jump), .jump_target_o(jump_target), .current_tag_o(current_tag),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o(mem_write_enable_o), .mem_address_o(mem_address_o),
        .mem_data_o(mem_data_o)
    );

    // decode holds either the live tag or the one just killed by a jump
    tag_in_step: assert property (@(posedge clk) disable iff (reset)
        tag_decode == current_tag || TAG_W'(tag_decode + 1'b1) == current_tag);

endmodule

/* tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_HALF       = 50;
    localparam int          RESET_CYCLES   = 16;
    localparam int          STORE_TIMEOUT  = 3000;
    localparam int          QUIET_CYCLES   = 300;
    localparam int          MEM_WORDS      = 256;
    localparam logic [31:0] RESET_VECTOR   = 32'h0;

    logic        clk;
    logic        reset;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_count;
    int          value_errors;
    int          other_errors;
    logic        prev_stall;
    logic [31:0] prev_address;

    rv_core #(.RESET_VECTOR(RESET_VECTOR)) rv_core_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .instruction_i(instruction_i),
        .mem_data_i(mem_data_i), .instruction_address_o(instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o(mem_write_enable_o), .mem_address_o(mem_address_o),
        .mem_data_o(mem_data_o)
    );

    always #CLK_HALF clk = ~clk;

    // registered instruction read, one cycle late
    always @(posedge clk) begin
        instruction_i <= imem[instruction_address_o[9:2]];
    end

    always @(posedge clk) begin
        if (mem_write_enable_o != 4'b0000) begin
            dmem[mem_address_o[9:2]] <= mem_data_o;
        end else if (mem_operation_enable_o) begin
            mem_data_i <= dmem[mem_address_o[9:2]];
        end
    end

    // stall about one cycle in four
    always @(posedge clk) begin
        if (reset) begin
            stall_i <= 1'b0;
        end else begin
            stall_i <= ($urandom % 4) == 0;
        end
    end

    // in-order store check against the expected list
    always @(posedge clk) begin
        if (!reset && mem_write_enable_o != 4'b0000) begin
            if (mem_write_enable_o != 4'b1111) begin
                $display("FAIL %0t mem_write_enable_o expected %b actual %b", $time,
                         4'b1111, mem_write_enable_o);
                value_errors++;
            end
            if (mem_operation_enable_o != 1'b1) begin
                $display("FAIL %0t mem_operation_enable_o expected %b actual %b", $time,
                         1'b1, mem_operation_enable_o);
                value_errors++;
            end
            if (store_count >= exp_addr.size()) begin
                $display("unexpected extra store at time %0t to address %h", $time,
                         mem_address_o);
                other_errors++;
            end else begin
                if (mem_address_o != exp_addr[store_count]) begin
                    $display("FAIL %0t mem_address_o expected %h actual %h", $time,
                             exp_addr[store_count], mem_address_o);
                    value_errors++;
                end
                if (mem_data_o != exp_data[store_count]) begin
                    $display("FAIL %0t mem_data_o expected %h actual %h", $time,
                             exp_data[store_count], mem_data_o);
                    value_errors++;
                end
            end
            store_count <= store_count + 1;
        end
    end

    // fetch address must hold across a stalled edge
    always @(posedge clk) begin
        if (!reset && prev_stall && instruction_address_o != prev_address) begin
            $display("FAIL %0t instruction_address_o expected %h actual %h", $time,
                     prev_address, instruction_address_o);
            value_errors++;
        end
        prev_stall   <= stall_i;
        prev_address <= instruction_address_o;
    end

    task automatic read_program_file();
        int          fd;
        int          n;
        logic [31:0] a;
        logic [31:0] d;
        reg [8*120-1:0] line;
        n  = 0;
        fd = $fopen("program_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open program_stimulus.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "I %h", a) == 1) begin
                    imem[n] = a;
                    n++;
                end else if ($sscanf(line, "S %h %h", a, d) == 2) begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset_state();
        if (instruction_address_o != RESET_VECTOR) begin
            $display("FAIL %0t instruction_address_o expected %h actual %h", $time,
                     RESET_VECTOR, instruction_address_o);
            value_errors++;
        end
        if (mem_operation_enable_o != 1'b0) begin
            $display("FAIL %0t mem_operation_enable_o expected 0 actual %b", $time,
                     mem_operation_enable_o);
            value_errors++;
        end
        if (mem_write_enable_o != 4'b0000) begin
            $display("FAIL %0t mem_write_enable_o expected 0000 actual %b", $time,
                     mem_write_enable_o);
            value_errors++;
        end
    endtask

    initial begin
        int cycles;
        clk           = 1'b0;
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        prev_stall    = 1'b0;
        prev_address  = '0;
        store_count   = 0;
        value_errors  = 0;
        other_errors  = 0;
        void'($urandom(52));
        // opcode zero decodes as invalid, upper bits follow the word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {25'(i), 7'h00};
            dmem[i] = {16'hd0d0, 16'(i)};
        end
        read_program_file();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_reset_state();
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state();

        cycles = 0;
        while (store_count < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < exp_addr.size()) begin
            $display("timeout: only %0d of %0d stores seen", store_count, exp_addr.size());
            other_errors++;
        end else begin
            // core now spins in its final loop
            repeat (QUIET_CYCLES) @(posedge clk);
            if (store_count != exp_addr.size()) begin
                $display("store count %0d differs from expected %0d", store_count,
                         exp_addr.size());
                other_errors++;
            end
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* program_stimulus.txt */
# I word : instruction memory from address 0, one word per line
# S address data : expected stores, in order
I 00500093 addi x1,x0,5
I 00708113 addi x2,x1,7
I 002081B3 add x3,x1,x2
I 40118233 sub x4,x3,x1
I 10302023 sw x3,0x100(x0)
I 10402223 sw x4,0x104(x0)
I 123452B7 lui x5,0x12345
I 0FF2C313 xori x6,x5,0xff
I 10602423 sw x6,0x108(x0)
I 0022E3B3 or x7,x5,x2
I 10702623 sw x7,0x10c(x0)
I 00D22413 slti x8,x4,13
I FFF00513 addi x10,x0,-1
I 00A0B4B3 sltu x9,x1,x10
I 00A0A5B3 slt x11,x1,x10
I 40958633 sub x12,x11,x9
I 10C02823 sw x12,0x110(x0)
I 7F067693 andi x13,x12,0x7f0
I 008686B3 add x13,x13,x8
I 10D02A23 sw x13,0x114(x0)
I 10002703 lw x14,0x100(x0)
I 00370713 addi x14,x14,3
I 10E02C23 sw x14,0x118(x0)
I 00208463 beq x1,x2,+8 not taken
I 10302E23 sw x3,0x11c(x0)
I 00209463 bne x1,x2,+8 taken
I 1E102823 sw x1,0x1f0(x0) shadow
I 00108463 beq x1,x1,+8 taken
I 1E102A23 sw x1,0x1f4(x0) shadow
I 008007EF jal x15,+8
I 1E102C23 sw x1,0x1f8(x0) shadow
I 12F02023 sw x15,0x120(x0)
I 0000006F jal x0,0
S 00000100 00000011
S 00000104 0000000C
S 00000108 123450FF
S 0000010C 1234500C
S 00000110 FFFFFFFF
S 00000114 000007F1
S 00000118 00000014
S 0000011C 00000011
S 00000120 00000078

/* list.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regbank.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rv_core
FILELIST = list.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
